//--- logic/life_pkg.sv
// shared board sizes, cell rule constants and sequencer states, imported by the engine and testbench
package life_pkg;

   // default board size
   // the top level passes these down as ROWS and COLS
   localparam int BOARD_ROWS = 16;
   localparam int BOARD_COLS = 16;
   localparam int BOARD_CELLS = BOARD_ROWS * BOARD_COLS;

   // one whole board at the default size
   // bit 0 is row 0, column 0, index is row * cols + col
   typedef logic [BOARD_CELLS-1:0] board_t;

   // live neighbors of one cell, 0 to 8
   typedef logic [3:0] neighbor_count_t;

   // rule thresholds
   localparam neighbor_count_t BIRTH_COUNT   = 4'd3;
   localparam neighbor_count_t SURVIVE_COUNT = 4'd2;

   // nine-bit window around a cell, row-major, center in the middle
   localparam int WINDOW_BITS   = 9;
   localparam int WINDOW_CENTER = 4;

   // run/pause sequencer states
   typedef enum logic [1:0] {
      SEQ_IDLE    = 2'b00,
      SEQ_RUNNING = 2'b01,
      SEQ_PAUSED  = 2'b10
   } seq_state_t;

endpackage

//--- logic/life_cell.sv
// next state of a single cell from its 3x3 window, one instance per board position
`timescale 1ns/1ns

module life_cell
   import life_pkg::*;
(
   input  logic [WINDOW_BITS-1:0] window,
   output logic                   next_alive
);

   neighbor_count_t count;
   logic            center;
   logic            birth;
   logic            survive;

   assign center = window[WINDOW_CENTER];

   // add up the eight outer bits
   always_comb begin
      count = '0;
      for (int i = 0; i < WINDOW_BITS; i++) begin
         if (i != WINDOW_CENTER) begin
            count = count + neighbor_count_t'(window[i]);
         end
      end
   end

   // exactly three brings a cell to life, two keeps a live one
   assign birth   = (count == BIRTH_COUNT);
   assign survive = (count == SURVIVE_COUNT) && center;

   assign next_alive = birth || survive;

endmodule

//--- logic/life_generation.sv
// combinational next generation of a whole board, dead cells assumed beyond every edge
`timescale 1ns/1ns

module life_generation #(
   parameter int ROWS = 16,
   parameter int COLS = 16
) (
   input  logic [ROWS*COLS-1:0] grid,
   output logic [ROWS*COLS-1:0] next_grid
);

   genvar r;
   genvar c;
   genvar wr;
   genvar wc;

   generate
      for (r = 0; r < ROWS; r++) begin : g_row
         for (c = 0; c < COLS; c++) begin : g_col

            // 3x3 neighborhood, bit 0 is up-left, bit 4 the cell itself
            logic [8:0] window;

            for (wr = 0; wr < 3; wr++) begin : g_win_row
               for (wc = 0; wc < 3; wc++) begin : g_win_col
                  localparam int NR = r + wr - 1;
                  localparam int NC = c + wc - 1;

                  if (NR >= 0 && NR < ROWS && NC >= 0 && NC < COLS) begin : g_inside
                     assign window[wr*3 + wc] = grid[NR*COLS + NC];
                  end else begin : g_outside
                     // off the board
                     assign window[wr*3 + wc] = 1'b0;
                  end
               end
            end

            life_cell u_cell (
               .window     (window),
               .next_alive (next_grid[r*COLS + c])
            );

         end
      end
   endgenerate

endmodule

//--- logic/life_board.sv
// board register that loads a pattern or steps one generation per clock
`timescale 1ns/1ns

module life_board #(
   parameter int ROWS = 16,
   parameter int COLS = 16
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 load,
   input  logic                 advance,
   input  logic [ROWS*COLS-1:0] initial_state,
   output logic [ROWS*COLS-1:0] grid
);

   logic [ROWS*COLS-1:0] next_grid;

   life_generation #(
      .ROWS (ROWS),
      .COLS (COLS)
   ) u_generation (
      .grid      (grid),
      .next_grid (next_grid)
   );

   // load wins over advance, though the sequencer never raises both
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         grid <= '0;
      end else if (load) begin
         grid <= initial_state;
      end else if (advance) begin
         grid <= next_grid;
      end
   end

   // no control, no change on the following edge
   board_holds_when_idle: assert property (
      @(posedge clk) disable iff (reset)
      (!load && !advance) |=> $stable(grid)
   );

endmodule

//--- logic/life_sequencer.sv
// idle/running/paused control for the board, turns the run level into load and advance
`timescale 1ns/1ns

module life_sequencer
   import life_pkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic run,
   output logic load,
   output logic advance
);

   seq_state_t state;
   seq_state_t next_state;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= SEQ_IDLE;
      end else begin
         state <= next_state;
      end
   end

   // idle is left only by run, and only reset brings it back
   always_comb begin
      next_state = state;
      case (state)
         SEQ_IDLE: begin
            if (run) begin
               next_state = SEQ_RUNNING;
            end
         end
         SEQ_RUNNING: begin
            if (!run) begin
               next_state = SEQ_PAUSED;
            end
         end
         SEQ_PAUSED: begin
            if (run) begin
               next_state = SEQ_RUNNING;
            end
         end
         default: begin
            next_state = SEQ_IDLE;
         end
      endcase
   end

   // loading while idle, stepping on run otherwise
   assign load    = (state == SEQ_IDLE);
   assign advance = (state != SEQ_IDLE) && run;

   load_advance_exclusive: assert property (
      @(posedge clk) disable iff (reset)
      !(load && advance)
   );

   // once started, the board is never reloaded until reset
   no_reload_after_start: assert property (
      @(posedge clk) disable iff (reset)
      !load |=> !load
   );

endmodule

//--- logic/life_top.sv
// top level of the life engine, sequencer driving the board register
`timescale 1ns/1ns

module life_top
   import life_pkg::*;
#(
   parameter int ROWS = BOARD_ROWS,
   parameter int COLS = BOARD_COLS
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 run,
   input  logic [ROWS*COLS-1:0] initial_state,
   output logic [ROWS*COLS-1:0] grid
);

   logic load;
   logic advance;

   life_sequencer u_sequencer (
      .clk     (clk),
      .reset   (reset),
      .run     (run),
      .load    (load),
      .advance (advance)
   );

   life_board #(
      .ROWS (ROWS),
      .COLS (COLS)
   ) u_board (
      .clk           (clk),
      .reset         (reset),
      .load          (load),
      .advance       (advance),
      .initial_state (initial_state),
      .grid          (grid)
   );

endmodule

//--- test/life_ref_model.svh
// reference model of one life generation at the default board size, included by the testbench
`ifndef LIFE_REF_MODEL_SVH
`define LIFE_REF_MODEL_SVH

localparam int CELL_INDEX_BITS = $clog2(BOARD_CELLS);

// flat position of a cell, row-major
function automatic logic [CELL_INDEX_BITS-1:0] cell_index(input int row, input int col);
   return CELL_INDEX_BITS'(row * BOARD_COLS + col);
endfunction

// anything off the board reads as dead
function automatic logic cell_alive(input board_t board, input int row, input int col);
   if (row < 0 || row >= BOARD_ROWS || col < 0 || col >= BOARD_COLS) begin
      return 1'b0;
   end
   return board[cell_index(row, col)];
endfunction

function automatic board_t with_cell(input board_t board, input int row, input int col);
   board_t result;
   result = board;
   result[cell_index(row, col)] = 1'b1;
   return result;
endfunction

function automatic neighbor_count_t count_neighbors(
   input board_t board,
   input int     row,
   input int     col
);
   neighbor_count_t total;
   total = '0;
   for (int dr = -1; dr <= 1; dr++) begin
      for (int dc = -1; dc <= 1; dc++) begin
         if ((dr != 0 || dc != 0) && cell_alive(board, row + dr, col + dc)) begin
            total = total + 4'd1;
         end
      end
   end
   return total;
endfunction

// live cells survive on two or three neighbors, dead ones are born on three
function automatic board_t next_generation(input board_t board);
   board_t          result;
   neighbor_count_t neighbors;
   result = '0;
   for (int row = 0; row < BOARD_ROWS; row++) begin
      for (int col = 0; col < BOARD_COLS; col++) begin
         neighbors = count_neighbors(board, row, col);
         if (cell_alive(board, row, col)) begin
            if (neighbors == 4'd2 || neighbors == 4'd3) begin
               result = with_cell(result, row, col);
            end
         end else if (neighbors == 4'd3) begin
            result = with_cell(result, row, col);
         end
      end
   end
   return result;
endfunction

// small glider heading down and right, top-left of its box at the given cell
function automatic board_t glider_at(input int row, input int col);
   board_t result;
   result = '0;
   result = with_cell(result, row, col + 1);
   result = with_cell(result, row + 1, col + 2);
   result = with_cell(result, row + 2, col);
   result = with_cell(result, row + 2, col + 1);
   result = with_cell(result, row + 2, col + 2);
   return result;
endfunction

`endif

//--- test/life_tb.sv
// testbench for the life engine, directed tests checked against the reference model
`timescale 1ns/1ns

module life_tb
   import life_pkg::*;
();

`include "life_ref_model.svh"

   localparam int          CLOCK_HALF      = 4;
   localparam int          RESET_CYCLES    = 16;
   localparam int          EXPECTED_CYCLES = 600;
   localparam int          CYCLE_LIMIT     = EXPECTED_CYCLES * 3 + 200;
   localparam logic [31:0] RANDOM_SEED     = 32'h3ed4b079;

   logic   clk;
   logic   reset;
   logic   run;
   board_t initial_state;
   board_t grid;

   int error_count;
   int check_count;
   int tests_passed;
   int tests_failed;
   int errors_before_test;
   int cycle_count = 0;

   life_top #(
      .ROWS (BOARD_ROWS),
      .COLS (BOARD_COLS)
   ) dut (
      .clk           (clk),
      .reset         (reset),
      .run           (run),
      .initial_state (initial_state),
      .grid          (grid)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #CLOCK_HALF clk = ~clk;
      end
   end

   // hard stop well past the length of all tests
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
         $display("TESTS FAILED");
         $finish;
      end
   end

   task automatic check_board(input board_t expected, input board_t actual);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("MISMATCH at %0t ns: grid expected %h actual %h", $time, expected, actual);
      end
   endtask

   task automatic check_state(input seq_state_t expected, input seq_state_t actual);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("MISMATCH at %0t ns: state expected %s actual %s",
                  $time, expected.name(), actual.name());
      end
   endtask

   task automatic begin_test();
      errors_before_test = error_count;
   endtask

   task automatic end_test(input string name);
      if (error_count == errors_before_test) begin
         tests_passed++;
         $display("test %s: passed", name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, error_count - errors_before_test);
      end
   endtask

   function automatic board_t random_board();
      board_t result;
      result = '0;
      for (int i = 0; i < BOARD_CELLS / 32; i++) begin
         result = (result << 32) | board_t'($urandom());
      end
      return result;
   endfunction

   // leaves run low and the sequencer idle
   task automatic apply_reset(input int cycles);
      @(posedge clk);
      reset <= 1'b1;
      run   <= 1'b0;
      repeat (cycles) @(posedge clk);
      reset <= 1'b0;
   endtask

   // the first edge with run high still loads the pattern
   task automatic start_run(input board_t pattern);
      apply_reset(3);
      initial_state <= pattern;
      run           <= 1'b1;
      @(posedge clk);
      @(negedge clk);
      check_board(pattern, grid);
      check_state(SEQ_RUNNING, dut.u_sequencer.state);
   endtask

   task automatic run_generations(input int count, inout board_t model);
      repeat (count) begin
         @(posedge clk);
         @(negedge clk);
         model = next_generation(model);
         check_board(model, grid);
      end
   endtask

   task automatic test_load_idle();
      board_t first;
      board_t second;
      begin_test();
      first  = random_board();
      second = with_cell(with_cell(with_cell('0, 5, 5), 6, 5), 7, 5);
      initial_state <= first;
      @(posedge clk);
      @(negedge clk);
      check_board(first, grid);
      check_state(SEQ_IDLE, dut.u_sequencer.state);
      @(posedge clk);
      initial_state <= second;
      @(negedge clk);
      // new pattern not in yet
      check_board(first, grid);
      @(posedge clk);
      @(negedge clk);
      check_board(second, grid);
      // a blinker would flip if it were evolving
      repeat (4) begin
         @(posedge clk);
         @(negedge clk);
         check_board(second, grid);
      end
      end_test("load while idle");
   endtask

   task automatic test_blinker();
      board_t vertical;
      board_t horizontal;
      board_t model;
      begin_test();
      vertical   = with_cell(with_cell(with_cell('0, 7, 8), 8, 8), 9, 8);
      horizontal = with_cell(with_cell(with_cell('0, 8, 7), 8, 8), 8, 9);
      start_run(vertical);
      model = vertical;
      run_generations(1, model);
      check_board(horizontal, grid);
      run_generations(1, model);
      check_board(vertical, grid);
      run_generations(4, model);
      end_test("blinker");
   endtask

   task automatic test_edges();
      board_t block;
      board_t model;
      begin_test();
      block = with_cell(with_cell(with_cell(with_cell('0, 0, 0), 0, 1), 1, 0), 1, 1);
      start_run(block);
      repeat (4) begin
         @(posedge clk);
         @(negedge clk);
         check_board(block, grid);
      end
      // reaches the bottom-right corner and breaks up there
      model = glider_at(9, 9);
      start_run(model);
      run_generations(40, model);
      end_test("edges and corners");
   endtask

   task automatic test_pause_resume();
      board_t model;
      begin_test();
      model = glider_at(2, 2);
      start_run(model);
      run_generations(4, model);
      @(posedge clk);
      run <= 1'b0;
      @(negedge clk);
      // run was still high at this edge
      model = next_generation(model);
      check_board(model, grid);
      repeat (6) begin
         @(posedge clk);
         @(negedge clk);
         check_board(model, grid);
      end
      check_state(SEQ_PAUSED, dut.u_sequencer.state);
      @(posedge clk);
      run <= 1'b1;
      @(negedge clk);
      check_board(model, grid);
      run_generations(6, model);
      check_state(SEQ_RUNNING, dut.u_sequencer.state);
      end_test("pause and resume");
   endtask

   task automatic test_random_boards();
      board_t model;
      begin_test();
      repeat (3) begin
         model = random_board();
         start_run(model);
         run_generations(20, model);
      end
      end_test("random boards");
   endtask

   task automatic test_reset_mid_run();
      board_t model;
      board_t reloaded;
      begin_test();
      model = random_board();
      start_run(model);
      run_generations(3, model);
      @(posedge clk);
      reset <= 1'b1;
      @(negedge clk);
      check_board('0, grid);
      check_state(SEQ_IDLE, dut.u_sequencer.state);
      @(posedge clk);
      @(negedge clk);
      check_board('0, grid);
      reloaded = random_board();
      @(posedge clk);
      reset         <= 1'b0;
      run           <= 1'b0;
      initial_state <= reloaded;
      @(posedge clk);
      @(negedge clk);
      check_board(reloaded, grid);
      check_state(SEQ_IDLE, dut.u_sequencer.state);
      // idle again, so a new pattern keeps loading
      @(posedge clk);
      initial_state <= ~reloaded;
      @(posedge clk);
      @(negedge clk);
      check_board(~reloaded, grid);
      end_test("reset mid-run");
   endtask

   initial begin
      void'($urandom(RANDOM_SEED));
      error_count   = 0;
      check_count   = 0;
      tests_passed  = 0;
      tests_failed  = 0;
      reset         <= 1'b1;
      run           <= 1'b0;
      initial_state <= '0;

      repeat (RESET_CYCLES - 1) @(posedge clk);
      @(negedge clk);
      check_board('0, grid);
      @(posedge clk);
      reset <= 1'b0;

      test_load_idle();
      test_blinker();
      test_edges();
      test_pause_resume();
      test_random_boards();
      test_reset_mid_run();

      $display("summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
               tests_passed, tests_failed, check_count, error_count);
      if (error_count == 0 && tests_failed == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- project.f
+incdir+test
logic/life_pkg.sv
logic/life_cell.sv
logic/life_generation.sv
logic/life_board.sv
logic/life_sequencer.sv
logic/life_top.sv
test/life_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the life engine testbench with Verilator, runs it, and checks the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module life_tb -f project.f \
   || { echo "build failed"; exit 1; }

output="$(./obj_dir/Vlife_tb)"
printf '%s\n' "$output"

printf '%s\n' "$output" | grep -qx "TESTS PASSED" \
   && echo "simulation result: pass" \
   || { echo "simulation result: fail"; exit 1; }
